/* testbench/tb_program_input.txt */
// Word 0 instruction count, word 1 store count, then instruction words from RESET_PC
// After the program, one expected store per line: address, sel, data
0000001E 00000012
123450B7 40102023  // lui  x1, 0x12345        ; sw x1, 0x400(x0)
67808113 40202223  // addi x2, x1, 0x678      ; sw x2, 0x404(x0)
FFF00193 40302423  // addi x3, x0, -1         ; sw x3, 0x408(x0)
0F014213 40402623  // xori x4, x2, 0x0f0      ; sw x4, 0x40c(x0)
00F0E293 40502823  // ori  x5, x1, 0x00f      ; sw x5, 0x410(x0)
F0017313 40602A23  // andi x6, x2, -256       ; sw x6, 0x414(x0)
003103B3 40702C23  // add  x7, x2, x3         ; sw x7, 0x418(x0)
40208433 40802E23  // sub  x8, x1, x2         ; sw x8, 0x41c(x0)
004174B3 42902023  // and  x9, x2, x4         ; sw x9, 0x420(x0)
0062E533 42A02223  // or   x10, x5, x6        ; sw x10, 0x424(x0)
0030C5B3 42B02423  // xor  x11, x1, x3        ; sw x11, 0x428(x0)
00210033 42002623  // add  x0, x2, x2         ; sw x0, 0x42c(x0)
50200023 502000A3  // sb   x2, 0x500(x0)      ; sb x2, 0x501(x0)
50700123 502001A3  // sb   x7, 0x502(x0)      ; sb x2, 0x503(x0)
50201223 50801323  // sh   x2, 0x504(x0)      ; sh x8, 0x506(x0)
// Expected stores
00000400 0000000F 12345000
00000404 0000000F 12345678
00000408 0000000F FFFFFFFF
0000040C 0000000F 12345688
00000410 0000000F 1234500F
00000414 0000000F 12345600
00000418 0000000F 12345677
0000041C 0000000F FFFFF988
00000420 0000000F 12345608
00000424 0000000F 1234560F
00000428 0000000F EDCBAFFF
0000042C 0000000F 00000000
00000500 00000001 78787878
00000500 00000002 78787878
00000500 00000004 77777777
00000500 00000008 78787878
00000504 00000003 56785678
00000504 0000000C F988F988

/* sources.f */
src/core_pkg.sv
src/serial_alu.sv
src/serial_regfile.sv
src/instr_decoder.sv
src/instr_sequencer.sv
src/store_unit.sv
src/serial_core_top.sv
testbench/tb_serial_core.sv

/* testbench/tb_serial_core.sv */
`timescale 1ns/10ps

module tb_serial_core;

   import core_pkg::*;

   localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0100;
   localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;
   localparam int              MEM_WORDS = 256;

   logic            clk;
   logic            reset;
   ibus_req_t       ibus_req;
   ibus_rsp_t       ibus_rsp;
   dbus_req_t       dbus_req;
   logic            dbus_ack;

   // Program file image, see tb_program_input.txt for the layout
   logic [XLEN-1:0] mem [0:MEM_WORDS-1];
   int              n_instr;
   int              n_store;
   int              tests;
   int              failed_tests;
   int              errors;
   int              cycles;
   int              limit;
   int              store_idx;
   int              fetch_count;
   bit              fetch_ok;
   bit              reset_ok;
   integer          seed;
   logic [XLEN-1:0] expected_pc;

   serial_core_top #(
      .RESET_PC(RESET_PC)
   ) serial_core_top_i (
      .clk       (clk),
      .i_reset   (reset),
      .o_ibus    (ibus_req),
      .i_ibus    (ibus_rsp),
      .o_dbus    (dbus_req),
      .i_dbus_ack(dbus_ack)
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic compare_ibus_adr(input logic [XLEN-1:0] actual,
                                   input logic [XLEN-1:0] expected, output bit ok);
      ok = (actual === expected);
      if (!ok) begin
         errors++;
         $display("Mismatch at %0t: o_ibus.adr got %h expected %h", $time, actual, expected);
      end
   endtask

   task automatic compare_dbus(input dbus_req_t actual, input dbus_req_t expected,
                               output bit ok);
      ok = 1'b1;
      if (actual.adr !== expected.adr) begin
         ok = 1'b0;
         $display("Mismatch at %0t: o_dbus.adr got %h expected %h", $time, actual.adr,
                  expected.adr);
      end
      if (actual.sel !== expected.sel) begin
         ok = 1'b0;
         $display("Mismatch at %0t: o_dbus.sel got %b expected %b", $time, actual.sel,
                  expected.sel);
      end
      if (actual.dat !== expected.dat) begin
         ok = 1'b0;
         $display("Mismatch at %0t: o_dbus.dat got %h expected %h", $time, actual.dat,
                  expected.dat);
      end
      if (!ok) begin
         errors++;
      end
   endtask

   task automatic check_idle(inout bit ok);
      if (ibus_req.cyc !== 1'b0 || dbus_req.cyc !== 1'b0) begin
         errors++;
         ok = 1'b0;
         $display("Mismatch at %0t: o_ibus.cyc/o_dbus.cyc got %b/%b expected 0/0", $time,
                  ibus_req.cyc, dbus_req.cyc);
      end
   endtask

   task automatic report_test(input string name, input bit ok);
      tests++;
      if (ok) begin
         $display("test %s: ok", name);
      end else begin
         failed_tests++;
         $display("test %s: error", name);
      end
   endtask

   function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] adr);
      logic [XLEN-1:0] idx;
      idx = (adr - RESET_PC) >> 2;
      // Past the end of the program the core runs NOPs
      if (idx < n_instr) begin
         return mem[2 + idx];
      end
      return NOP_INSTR;
   endfunction

   function automatic dbus_req_t expected_store(input int idx);
      dbus_req_t req;
      int        base;
      base    = 2 + n_instr + 3 * idx;
      req     = '0;
      req.adr = mem[base];
      req.sel = mem[base + 1][3:0];
      req.dat = mem[base + 2];
      return req;
   endfunction

   // Both bus slaves in one process so the random draws keep a fixed order
   initial begin : bus_models
      int              fetch_wait;
      int              store_wait;
      bit              fetch_busy;
      bit              store_busy;
      bit              store_ok;
      bit              ok;
      logic [XLEN-1:0] fetch_adr;
      dbus_req_t       store_req;
      fetch_busy = 1'b0;
      store_busy = 1'b0;
      fetch_wait = 0;
      store_wait = 0;
      store_ok   = 1'b1;
      forever begin
         @(posedge clk);
         #1;
         // Wishbone classic, stb follows cyc on both buses
         if (ibus_req.stb !== ibus_req.cyc) begin
            errors++;
            fetch_ok = 1'b0;
            $display("Mismatch at %0t: o_ibus.stb got %b expected %b", $time, ibus_req.stb,
                     ibus_req.cyc);
         end
         if (dbus_req.stb !== dbus_req.cyc) begin
            errors++;
            store_ok = 1'b0;
            $display("Mismatch at %0t: o_dbus.stb got %b expected %b", $time, dbus_req.stb,
                     dbus_req.cyc);
         end

         if (ibus_rsp.ack) begin
            ibus_rsp.ack = 1'b0;
         end else if (ibus_req.cyc) begin
            if (!fetch_busy) begin
               fetch_busy = 1'b1;
               fetch_wait = $random(seed) & 3;
               fetch_adr  = ibus_req.adr;
               compare_ibus_adr(ibus_req.adr, expected_pc, ok);
               fetch_ok    = fetch_ok & ok;
               expected_pc = expected_pc + 4;
               fetch_count++;
            end else if (ibus_req.adr !== fetch_adr) begin
               errors++;
               fetch_ok = 1'b0;
               $display("Fetch address changed at %0t while ack was held off", $time);
            end
            if (fetch_wait == 0) begin
               ibus_rsp.dat = fetch_word(ibus_req.adr);
               ibus_rsp.ack = 1'b1;
               fetch_busy   = 1'b0;
            end else begin
               fetch_wait--;
            end
         end

         if (dbus_ack) begin
            dbus_ack = 1'b0;
         end else if (dbus_req.cyc) begin
            if (!store_busy) begin
               store_busy = 1'b1;
               store_wait = $random(seed) & 3;
               store_req  = dbus_req;
               if (store_idx >= n_store) begin
                  errors++;
                  store_ok = 1'b0;
                  $display("Unexpected store to %h at %0t", dbus_req.adr, $time);
               end else begin
                  compare_dbus(dbus_req, expected_store(store_idx), ok);
                  store_ok = store_ok & ok;
               end
               if (dbus_req.we !== 1'b1) begin
                  errors++;
                  store_ok = 1'b0;
                  $display("Store at %0t has write enable low", $time);
               end
            end else if (dbus_req !== store_req) begin
               errors++;
               store_ok = 1'b0;
               $display("Data bus request changed at %0t while ack was held off", $time);
            end
            if (store_wait == 0) begin
               dbus_ack   = 1'b1;
               store_busy = 1'b0;
               report_test($sformatf("store %0d to %h", store_idx, store_req.adr), store_ok);
               store_ok = 1'b1;
               store_idx++;
            end else begin
               store_wait--;
            end
         end
      end
   end

   initial begin : watchdog
      wait (limit > 0);
      while (cycles <= limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, %0d of %0d stores seen", cycles, store_idx, n_store);
      $display("Result: FAILED");
      $finish;
   end

   initial begin : main
      seed         = 32'h8009;
      tests        = 0;
      failed_tests = 0;
      errors       = 0;
      cycles       = 0;
      limit        = 0;
      store_idx    = 0;
      fetch_count  = 0;
      fetch_ok     = 1'b1;
      reset_ok     = 1'b1;
      expected_pc  = RESET_PC;
      reset        = 1'b1;
      ibus_rsp     = '0;
      dbus_ack     = 1'b0;
      $readmemh("testbench/tb_program_input.txt", mem);
      n_instr = mem[0];
      n_store = mem[1];
      limit   = n_instr * 48 + 200;
      if (n_store == 0) begin
         errors++;
         $display("Program file holds no expected stores");
      end

      repeat (16) begin
         @(posedge clk);
         #1;
         check_idle(reset_ok);
      end
      reset = 1'b0;
      // Cycle in which reset ends
      check_idle(reset_ok);
      @(posedge clk);
      #1;
      if (ibus_req.cyc !== 1'b1) begin
         errors++;
         reset_ok = 1'b0;
         $display("Instruction fetch did not start in the first cycle after reset");
      end
      report_test("reset", reset_ok);

      // One fetch past the last instruction shows the PC step after the final store
      wait (store_idx >= n_store && fetch_count > n_instr);
      report_test("fetch order", fetch_ok);
      $display("Tests: %0d, failed: %0d, mismatches: %0d", tests, failed_tests, errors);
      if (failed_tests == 0 && errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* src/serial_core_top.sv */
`timescale 1ns/10ps

module serial_core_top #(
   parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic                clk,
   input  logic                i_reset,
   output core_pkg::ibus_req_t o_ibus,
   input  core_pkg::ibus_rsp_t i_ibus,
   output core_pkg::dbus_req_t o_dbus,
   input  logic                i_dbus_ack
);

   import core_pkg::*;

   dec_ctrl_t ctrl;
   cnt_t      cnt;
   logic      instr_valid;
   logic      exec;
   logic      store_go;
   logic      store_done;
   logic      imm_bit;
   logic      rs1_bit;
   logic      rs2_bit;
   logic      result_bit;

   instr_sequencer #(
      .RESET_PC(RESET_PC)
   ) state (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_ibus_ack   (i_ibus.ack),
      .o_ibus       (o_ibus),
      .i_ctrl       (ctrl),
      .i_store_done (store_done),
      .o_instr_valid(instr_valid),
      .o_exec       (exec),
      .o_cnt        (cnt),
      .o_store_go   (store_go)
   );

   instr_decoder decode (
      .clk          (clk),
      .i_instr_valid(instr_valid),
      .i_instr      (i_ibus.dat),
      .i_exec       (exec),
      .o_ctrl       (ctrl),
      .o_imm_bit    (imm_bit)
   );

   serial_alu alu (
      .clk         (clk),
      .i_exec      (exec),
      .i_cnt       (cnt),
      .i_ctrl      (ctrl),
      .i_rs1_bit   (rs1_bit),
      .i_rs2_bit   (rs2_bit),
      .i_imm_bit   (imm_bit),
      .o_result_bit(result_bit)
   );

   serial_regfile regfile (
      .clk      (clk),
      .i_exec   (exec),
      .i_cnt    (cnt),
      .i_ctrl   (ctrl),
      .i_rd_bit (result_bit),
      .o_rs1_bit(rs1_bit),
      .o_rs2_bit(rs2_bit)
   );

   // ALU result carries the store address, rs2 the store data
   store_unit store (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_exec      (exec),
      .i_ctrl      (ctrl),
      .i_addr_bit  (result_bit),
      .i_data_bit  (rs2_bit),
      .i_store_go  (store_go),
      .i_dbus_ack  (i_dbus_ack),
      .o_dbus      (o_dbus),
      .o_store_done(store_done)
   );

endmodule

/* src/store_unit.sv */
`timescale 1ns/10ps

module store_unit (
   input  logic                clk,
   input  logic                i_reset,
   input  logic                i_exec,
   input  core_pkg::dec_ctrl_t i_ctrl,
   input  logic                i_addr_bit,
   input  logic                i_data_bit,
   input  logic                i_store_go,
   input  logic                i_dbus_ack,
   output core_pkg::dbus_req_t o_dbus,
   output logic                o_store_done
);

   import core_pkg::*;

   logic [XLEN-1:0] addr_q;
   logic [XLEN-1:0] data_q;
   logic            dbus_cyc;
   logic [3:0]      sel;
   logic [XLEN-1:0] dat;

   // LSB first, so the full word is in place after 32 cycles
   always_ff @(posedge clk) begin
      if (i_exec) begin
         addr_q <= {i_addr_bit, addr_q[XLEN-1:1]};
         data_q <= {i_data_bit, data_q[XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         dbus_cyc <= 1'b0;
      end else if (i_store_go) begin
         dbus_cyc <= 1'b1;
      end else if (i_dbus_ack) begin
         dbus_cyc <= 1'b0;
      end
   end

   // Byte lanes and replicated data
   always_comb begin
      case (i_ctrl.mem_width)
         MW_BYTE: begin
            sel = 4'b0001 << addr_q[1:0];
            dat = {4{data_q[7:0]}};
         end
         MW_HALF: begin
            sel = 4'b0011 << {addr_q[1], 1'b0};
            dat = {2{data_q[15:0]}};
         end
         default: begin
            sel = 4'b1111;
            dat = data_q;
         end
      endcase
   end

   // Shift registers and ctrl hold still until the next fetch
   assign o_dbus.adr   = {addr_q[XLEN-1:2], 2'b00};
   assign o_dbus.dat   = dat;
   assign o_dbus.sel   = sel;
   assign o_dbus.we    = dbus_cyc;
   assign o_dbus.cyc   = dbus_cyc;
   assign o_dbus.stb   = dbus_cyc;
   assign o_store_done = dbus_cyc & i_dbus_ack;

endmodule

/* src/instr_sequencer.sv */
`timescale 1ns/10ps

module instr_sequencer #(
   parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic                clk,
   input  logic                i_reset,
   input  logic                i_ibus_ack,
   output core_pkg::ibus_req_t o_ibus,
   input  core_pkg::dec_ctrl_t i_ctrl,
   input  logic                i_store_done,
   output logic                o_instr_valid,
   output logic                o_exec,
   output core_pkg::cnt_t      o_cnt,
   output logic                o_store_go
);

   import core_pkg::*;

   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      STORE
   } phase_e;

   phase_e          phase;
   logic [XLEN-1:0] pc;
   logic            ibus_cyc;
   cnt_t            cnt;
   logic            store_go;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase    <= FETCH;
         pc       <= RESET_PC;
         ibus_cyc <= 1'b0;
         cnt      <= '0;
         store_go <= 1'b0;
      end else begin
         store_go <= 1'b0;
         case (phase)
            FETCH: begin
               // First request after reset starts here
               if (!ibus_cyc) begin
                  ibus_cyc <= 1'b1;
               end else if (i_ibus_ack) begin
                  ibus_cyc <= 1'b0;
                  phase    <= EXEC;
               end
            end
            EXEC: begin
               cnt <= cnt + CNT_W'(1);
               if (cnt == '1) begin
                  if (i_ctrl.opcode == OPC_STORE) begin
                     phase    <= STORE;
                     store_go <= 1'b1;
                  end else begin
                     phase    <= FETCH;
                     pc       <= pc + XLEN'(4);
                     ibus_cyc <= 1'b1;
                  end
               end
            end
            STORE: begin
               if (i_store_done) begin
                  phase    <= FETCH;
                  pc       <= pc + XLEN'(4);
                  ibus_cyc <= 1'b1;
               end
            end
            default: phase <= FETCH;
         endcase
      end
   end

   assign o_ibus.adr    = pc;
   assign o_ibus.cyc    = ibus_cyc;
   assign o_ibus.stb    = ibus_cyc;
   assign o_instr_valid = ibus_cyc & i_ibus_ack;
   assign o_exec        = (phase == EXEC);
   assign o_cnt         = cnt;
   assign o_store_go    = store_go;

endmodule

/* src/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
   input  logic                      clk,
   input  logic                      i_instr_valid,
   input  logic [core_pkg::XLEN-1:0] i_instr,
   input  logic                      i_exec,
   output core_pkg::dec_ctrl_t       o_ctrl,
   output logic                      o_imm_bit
);

   import core_pkg::*;

   dec_ctrl_t       ctrl_d;
   dec_ctrl_t       ctrl_q;
   logic [XLEN-1:0] imm_d;
   logic [XLEN-1:0] imm_q;
   logic [2:0]      funct3;
   logic [6:0]      funct7;

   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];

   always_comb begin
      ctrl_d           = '0;
      ctrl_d.opcode    = OPC_NONE;
      ctrl_d.alu_op    = ALU_ADD;
      ctrl_d.mem_width = MW_WORD;
      ctrl_d.rd        = i_instr[11:7];
      ctrl_d.rs1       = i_instr[19:15];
      ctrl_d.rs2       = i_instr[24:20];
      // I-type by default
      imm_d = {{20{i_instr[31]}}, i_instr[31:20]};

      case (i_instr[6:0])
         7'b0110111: begin
            ctrl_d.opcode   = OPC_LUI;
            ctrl_d.use_imm  = 1'b1;
            ctrl_d.rs1_zero = 1'b1;
            ctrl_d.rd_we    = 1'b1;
            imm_d           = {i_instr[31:12], 12'h000};
         end
         7'b0010011: begin
            ctrl_d.opcode  = OPC_OP_IMM;
            ctrl_d.use_imm = 1'b1;
            ctrl_d.rd_we   = 1'b1;
            case (funct3)
               3'b000:  ctrl_d.alu_op = ALU_ADD;
               3'b100:  ctrl_d.alu_op = ALU_XOR;
               3'b110:  ctrl_d.alu_op = ALU_OR;
               3'b111:  ctrl_d.alu_op = ALU_AND;
               default: begin
                  ctrl_d.opcode = OPC_NONE;
                  ctrl_d.rd_we  = 1'b0;
               end
            endcase
         end
         7'b0110011: begin
            ctrl_d.opcode = OPC_OP;
            ctrl_d.rd_we  = 1'b1;
            case ({funct7, funct3})
               10'b0000000_000: ctrl_d.alu_op = ALU_ADD;
               10'b0100000_000: ctrl_d.alu_op = ALU_SUB;
               10'b0000000_100: ctrl_d.alu_op = ALU_XOR;
               10'b0000000_110: ctrl_d.alu_op = ALU_OR;
               10'b0000000_111: ctrl_d.alu_op = ALU_AND;
               default: begin
                  ctrl_d.opcode = OPC_NONE;
                  ctrl_d.rd_we  = 1'b0;
               end
            endcase
         end
         7'b0100011: begin
            // Address is rs1 + S immediate
            ctrl_d.opcode  = OPC_STORE;
            ctrl_d.use_imm = 1'b1;
            imm_d          = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            case (funct3)
               3'b000:  ctrl_d.mem_width = MW_BYTE;
               3'b001:  ctrl_d.mem_width = MW_HALF;
               3'b010:  ctrl_d.mem_width = MW_WORD;
               default: ctrl_d.opcode    = OPC_NONE;
            endcase
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_instr_valid) begin
         ctrl_q <= ctrl_d;
         imm_q  <= imm_d;
      end else if (i_exec) begin
         imm_q <= {1'b0, imm_q[XLEN-1:1]};
      end
   end

   assign o_ctrl    = ctrl_q;
   assign o_imm_bit = imm_q[0];

endmodule

/* src/serial_regfile.sv */
`timescale 1ns/10ps

module serial_regfile (
   input  logic                clk,
   input  logic                i_exec,
   input  core_pkg::cnt_t      i_cnt,
   input  core_pkg::dec_ctrl_t i_ctrl,
   input  logic                i_rd_bit,
   output logic                o_rs1_bit,
   output logic                o_rs2_bit
);

   import core_pkg::*;

   // x1 to x31; x0 has no storage
   logic [XLEN-1:0] regs [1:31];
   logic            rs1_bit;
   logic            rs2_bit;
   logic            wr_en;

   always_comb begin
      rs1_bit = 1'b0;
      rs2_bit = 1'b0;
      if (i_ctrl.rs1 != '0) begin
         rs1_bit = regs[i_ctrl.rs1][i_cnt];
      end
      if (i_ctrl.rs2 != '0) begin
         rs2_bit = regs[i_ctrl.rs2][i_cnt];
      end
   end

   assign wr_en = i_exec & i_ctrl.rd_we & (i_ctrl.rd != '0);

   // Read above sees the old bit, new bit lands at the edge
   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[i_ctrl.rd][i_cnt] <= i_rd_bit;
      end
   end

   assign o_rs1_bit = rs1_bit;
   assign o_rs2_bit = rs2_bit;

endmodule

/* src/serial_alu.sv */
`timescale 1ns/10ps

module serial_alu (
   input  logic                clk,
   input  logic                i_exec,
   input  core_pkg::cnt_t      i_cnt,
   input  core_pkg::dec_ctrl_t i_ctrl,
   input  logic                i_rs1_bit,
   input  logic                i_rs2_bit,
   input  logic                i_imm_bit,
   output logic                o_result_bit
);

   import core_pkg::*;

   logic sub;
   logic op_a;
   logic op_b;
   logic add_b;
   logic carry_q;
   logic carry_in;
   logic sum;

   assign sub  = (i_ctrl.alu_op == ALU_SUB);
   assign op_a = i_ctrl.rs1_zero ? 1'b0 : i_rs1_bit;
   assign op_b = i_ctrl.use_imm ? i_imm_bit : i_rs2_bit;

   // Two's complement subtract: invert B, carry in of one
   assign add_b    = op_b ^ sub;
   assign carry_in = (i_cnt == '0) ? sub : carry_q;
   assign sum      = op_a ^ add_b ^ carry_in;

   always_ff @(posedge clk) begin
      if (i_exec) begin
         carry_q <= (op_a & add_b) | (carry_in & (op_a ^ add_b));
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_AND: o_result_bit = op_a & op_b;
         ALU_OR:  o_result_bit = op_a | op_b;
         ALU_XOR: o_result_bit = op_a ^ op_b;
         default: o_result_bit = sum;
      endcase
   end

endmodule

/* src/core_pkg.sv */
package core_pkg;

   parameter int XLEN  = 32;
   parameter int CNT_W = 5;
   parameter int REG_W = 5;

   typedef logic [CNT_W-1:0] cnt_t;
   typedef logic [REG_W-1:0] reg_idx_t;

   typedef enum logic [2:0] {
      OPC_LUI,
      OPC_OP_IMM,
      OPC_OP,
      OPC_STORE,
      OPC_NONE
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   typedef enum logic [1:0] {
      MW_BYTE,
      MW_HALF,
      MW_WORD
   } mem_width_e;

   // Decoded instruction, held for the whole instruction
   typedef struct packed {
      opcode_e    opcode;
      alu_op_e    alu_op;
      logic       use_imm;
      logic       rs1_zero;
      logic       rd_we;
      mem_width_e mem_width;
      reg_idx_t   rd;
      reg_idx_t   rs1;
      reg_idx_t   rs2;
   } dec_ctrl_t;

   typedef struct packed {
      logic [XLEN-1:0] adr;
      logic            cyc;
      logic            stb;
   } ibus_req_t;

   typedef struct packed {
      logic [XLEN-1:0] dat;
      logic            ack;
   } ibus_rsp_t;

   // Write-only data bus
   typedef struct packed {
      logic [XLEN-1:0] adr;
      logic [XLEN-1:0] dat;
      logic [3:0]      sel;
      logic            we;
      logic            cyc;
      logic            stb;
   } dbus_req_t;

endpackage
